// File: dcache_pkg.sv
`default_nettype none

package dcache_pkg;

    localparam int addr_width      = 32;
    localparam int line_bytes      = 8;
    localparam int line_width      = line_bytes * 8;
    localparam int offset_bits     = 3;
    localparam int n_lines         = 16;
    localparam int index_bits      = 4;
    localparam int tag_bits        = addr_width - index_bits - offset_bits;
    localparam int n_victim        = 4;
    localparam int victim_idx_bits = 2;
    localparam int mem_tag_bits    = 4;     // zero tag means no response
    localparam int line_addr_bits  = addr_width - offset_bits;

    // one cache line, seen as bytes, halves or words
    typedef union packed {
        logic [line_bytes-1:0][7:0]    bytes;
        logic [line_bytes/2-1:0][15:0] halves;
        logic [line_bytes/4-1:0][31:0] words;
    } line_t;

    typedef enum logic [0:0] {
        op_load  = 1'b0,
        op_store = 1'b1
    } mem_op_e;

    typedef enum logic [1:0] {
        size_byte = 2'd0,
        size_half = 2'd1,
        size_word = 2'd2
    } mem_size_e;

    // memory bus commands
    typedef enum logic [1:0] {
        bus_none  = 2'd0,
        bus_load  = 2'd1,
        bus_store = 2'd2
    } bus_cmd_e;

    typedef enum logic [2:0] {
        st_idle,
        st_write_back,
        st_fetch,
        st_fill_wait,
        st_complete
    } miss_state_e;

    typedef struct packed {
        logic                  valid;
        mem_op_e               op;
        mem_size_e             size;
        logic [addr_width-1:0] addr;
        logic [31:0]           store_data;
    } dcache_req_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] load_data;
    } dcache_resp_t;

    typedef struct packed {
        mem_op_e                   op;
        mem_size_e                 size;
        logic [tag_bits-1:0]       line_tag;
        logic [index_bits-1:0]     index;
        logic [offset_bits-1:0]    offset;
        logic [line_addr_bits-1:0] victim_tag;  // full line address
        logic [line_bytes-1:0]     byte_mask;
        logic [line_width-1:0]     lane_data;
    } decoded_req_t;

    typedef struct packed {
        bus_cmd_e              command;
        logic [addr_width-1:0] addr;        // line aligned
        line_t                 data;
    } mem_req_t;

endpackage

`default_nettype wire

// File: request_decode.sv
`timescale 1ns/1ps
`default_nettype none

module request_decode (
    input  dcache_pkg::dcache_req_t  req,
    output dcache_pkg::decoded_req_t dec
);
    import dcache_pkg::*;

    logic [offset_bits-1:0] offset;

    assign offset = req.addr[offset_bits-1:0];

    always_comb begin
        dec.op         = req.op;
        dec.size       = req.size;
        dec.line_tag   = req.addr[addr_width-1 -: tag_bits];
        dec.index      = req.addr[offset_bits +: index_bits];
        dec.offset     = offset;
        dec.victim_tag = req.addr[addr_width-1:offset_bits];

        // store data is copied to every lane, the mask picks the live bytes
        case (req.size)
            size_byte: begin
                dec.byte_mask = line_bytes'(1) << offset;
                dec.lane_data = {(line_bytes){req.store_data[7:0]}};
            end
            size_half: begin
                dec.byte_mask = line_bytes'(3) << {offset[2:1], 1'b0};
                dec.lane_data = {(line_bytes/2){req.store_data[15:0]}};
            end
            default: begin                                  // word
                dec.byte_mask = line_bytes'(15) << {offset[2], 2'b00};
                dec.lane_data = {(line_bytes/4){req.store_data}};
            end
        endcase
    end

endmodule

`default_nettype wire

// File: line_store.sv
`timescale 1ns/1ps
`default_nettype none

module line_store (
    input  logic                                   clock,
    input  logic                                   reset,
    input  dcache_pkg::decoded_req_t               dec,
    input  logic                                   accept,
    input  logic                                   fill_valid,
    input  dcache_pkg::line_t                      fill_line,
    output logic                                   main_hit,
    output logic                                   victim_hit,
    output dcache_pkg::line_t                      hit_line,
    output logic                                   main_victim_valid,
    output dcache_pkg::line_t                      lru_line,
    output logic [dcache_pkg::addr_width-1:0]      lru_addr,
    output logic                                   lru_valid,
    output logic                                   lru_dirty
);
    import dcache_pkg::*;

    // direct-mapped main cache
    logic [n_lines-1:0]        main_valid;
    logic [n_lines-1:0]        main_dirty;
    logic [tag_bits-1:0]       main_tag  [n_lines];
    line_t                     main_data [n_lines];

    // fully associative victim cache
    logic [n_victim-1:0]        vic_valid;
    logic [n_victim-1:0]        vic_dirty;
    logic [line_addr_bits-1:0]  vic_tag  [n_victim];
    line_t                      vic_data [n_victim];
    logic [victim_idx_bits-1:0] vic_rank [n_victim];   // higher is more recent

    logic [victim_idx_bits-1:0] hit_idx;
    logic [victim_idx_bits-1:0] lru_idx;
    decoded_req_t               pend;                  // request that missed

    function automatic line_t merge(line_t old, decoded_req_t d);
        line_t res;
        res = old;
        for (int b = 0; b < line_bytes; b++) begin
            if (d.byte_mask[b])
                res.bytes[b] = d.lane_data[8*b +: 8];
        end
        return res;
    endfunction

    assign main_hit          = main_valid[dec.index] && (main_tag[dec.index] == dec.line_tag);
    assign main_victim_valid = main_valid[dec.index];

    always_comb begin
        victim_hit = 1'b0;
        hit_idx    = '0;
        for (int i = 0; i < n_victim; i++) begin
            if (vic_valid[i] && (vic_tag[i] == dec.victim_tag)) begin
                victim_hit = 1'b1;
                hit_idx    = victim_idx_bits'(i);
            end
        end
    end

    assign hit_line = main_hit ? main_data[dec.index] : vic_data[hit_idx];

    // the lowest free slot wins over the lowest rank
    always_comb begin
        logic [victim_idx_bits-1:0] min_rank;
        min_rank = '1;
        lru_idx  = '0;
        for (int i = 0; i < n_victim; i++) begin
            if (vic_rank[i] < min_rank) begin
                min_rank = vic_rank[i];
                lru_idx  = victim_idx_bits'(i);
            end
        end
        for (int i = n_victim - 1; i >= 0; i--) begin
            if (!vic_valid[i])
                lru_idx = victim_idx_bits'(i);
        end
    end

    assign lru_line  = vic_data[lru_idx];
    assign lru_addr  = {vic_tag[lru_idx], {offset_bits{1'b0}}};
    assign lru_valid = vic_valid[lru_idx];
    assign lru_dirty = vic_dirty[lru_idx];

    always_ff @(posedge clock) begin
        if (reset) begin
            main_valid <= '0;
            main_dirty <= '0;
            vic_valid  <= '0;
            vic_dirty  <= '0;
            for (int i = 0; i < n_victim; i++)
                vic_rank[i] <= '0;
        end else if (fill_valid) begin
            main_valid[pend.index] <= 1'b1;
            main_dirty[pend.index] <= (pend.op == op_store);
            if (main_valid[pend.index]) begin              // old line drops to victim cache
                vic_valid[lru_idx] <= 1'b1;
                vic_dirty[lru_idx] <= main_dirty[pend.index];
                vic_rank[lru_idx]  <= '0;
            end
        end else if (accept) begin
            if (main_hit) begin
                if (dec.op == op_store)
                    main_dirty[dec.index] <= 1'b1;
            end else if (victim_hit) begin
                for (int i = 0; i < n_victim; i++) begin
                    if (victim_idx_bits'(i) == hit_idx)
                        vic_rank[i] <= '1;
                    else if (vic_rank[i] != '0)
                        vic_rank[i] <= vic_rank[i] - victim_idx_bits'(1);
                end
                if (dec.op == op_store)
                    vic_dirty[hit_idx] <= 1'b1;
            end
        end
    end

    // tags and line data
    always_ff @(posedge clock) begin
        if (accept)
            pend <= dec;
        if (fill_valid) begin
            main_tag[pend.index]  <= pend.line_tag;
            main_data[pend.index] <= (pend.op == op_store) ? merge(fill_line, pend) : fill_line;
            if (main_valid[pend.index]) begin
                vic_tag[lru_idx]  <= {main_tag[pend.index], pend.index};
                vic_data[lru_idx] <= main_data[pend.index];
            end
        end else if (accept && dec.op == op_store) begin
            if (main_hit)
                main_data[dec.index] <= merge(main_data[dec.index], dec);
            else if (victim_hit)
                vic_data[hit_idx] <= merge(vic_data[hit_idx], dec);
        end
    end

endmodule

`default_nettype wire

// File: miss_handler.sv
`timescale 1ns/1ps
`default_nettype none

module miss_handler (
    input  logic                                  clock,
    input  logic                                  reset,
    input  logic                                  req_valid,
    input  dcache_pkg::decoded_req_t              dec,
    input  logic                                  main_hit,
    input  logic                                  victim_hit,
    input  logic                                  main_victim_valid,
    input  logic                                  lru_valid,
    input  logic                                  lru_dirty,
    input  logic [dcache_pkg::addr_width-1:0]     lru_addr,
    input  dcache_pkg::line_t                     lru_line,
    output dcache_pkg::mem_req_t                  mem_req,
    input  logic [dcache_pkg::mem_tag_bits-1:0]   mem_response,
    input  logic [dcache_pkg::mem_tag_bits-1:0]   mem_tag,
    input  dcache_pkg::line_t                     mem_data,
    output logic                                  ready,
    output logic                                  accept,
    output logic                                  fill_valid,
    output dcache_pkg::line_t                     fill_line,
    output logic                                  miss_done
);
    import dcache_pkg::*;

    miss_state_e             state;
    miss_state_e             next_state;
    logic [addr_width-1:0]   miss_addr;     // line address of the missing request
    logic [mem_tag_bits-1:0] tag_q;         // tag memory gave the line load
    line_t                   fill_q;
    logic                    mem_accepted;
    logic                    tag_match;

    assign ready        = (state == st_idle);
    assign accept       = req_valid && ready;
    assign mem_accepted = (mem_response != '0);
    assign tag_match    = (state == st_fill_wait) && (mem_tag == tag_q);

    assign fill_valid = tag_match;
    assign fill_line  = (state == st_fill_wait) ? mem_data : fill_q;  // held for the response
    assign miss_done  = (state == st_complete);

    always_comb begin
        next_state = state;
        case (state)
            st_idle: begin
                if (accept && !(main_hit || victim_hit)) begin
                    // a dirty victim is lost only if the main line moves into a full victim cache
                    if (main_victim_valid && lru_valid && lru_dirty)
                        next_state = st_write_back;
                    else
                        next_state = st_fetch;
                end
            end
            st_write_back: if (mem_accepted) next_state = st_fetch;
            st_fetch:      if (mem_accepted) next_state = st_fill_wait;
            st_fill_wait:  if (tag_match) next_state = st_complete;
            st_complete:   next_state = st_idle;
            default:       next_state = st_idle;
        endcase
    end

    // command stays steady until memory accepts it
    always_comb begin
        mem_req.command = bus_none;
        mem_req.addr    = '0;
        mem_req.data    = '0;
        case (state)
            st_write_back: begin
                mem_req.command = bus_store;
                mem_req.addr    = lru_addr;
                mem_req.data    = lru_line;
            end
            st_fetch: begin
                mem_req.command = bus_load;
                mem_req.addr    = miss_addr;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset)
            state <= st_idle;
        else
            state <= next_state;
    end

    always_ff @(posedge clock) begin
        if (accept)
            miss_addr <= {dec.victim_tag, {offset_bits{1'b0}}};
        if (state == st_fetch && mem_accepted)
            tag_q <= mem_response;
        if (tag_match)
            fill_q <= mem_data;
    end

endmodule

`default_nettype wire

// File: load_align.sv
`timescale 1ns/1ps
`default_nettype none

module load_align (
    input  logic                      clock,
    input  logic                      reset,
    input  dcache_pkg::line_t         hit_line,
    input  dcache_pkg::line_t         fill_line,
    input  logic                      accept,
    input  logic                      hit,
    input  logic                      miss_done,
    input  dcache_pkg::decoded_req_t  dec,
    output dcache_pkg::dcache_resp_t  resp
);
    import dcache_pkg::*;

    logic                   pend_hit;   // a hit was accepted last cycle
    logic [offset_bits-1:0] pend_offset;
    mem_size_e              pend_size;
    mem_op_e                pend_op;
    line_t                  line_q;
    line_t                  src;
    logic [31:0]            sel;

    always_ff @(posedge clock) begin
        if (reset)
            pend_hit <= 1'b0;
        else
            pend_hit <= accept && hit;
    end

    always_ff @(posedge clock) begin
        if (accept) begin
            pend_offset <= dec.offset;
            pend_size   <= dec.size;
            pend_op     <= dec.op;
            line_q      <= hit_line;
        end
    end

    assign src = pend_hit ? line_q : fill_line;

    always_comb begin
        case (pend_size)
            size_byte: sel = {24'b0, src.bytes[pend_offset]};
            size_half: sel = {16'b0, src.halves[pend_offset[2:1]]};
            default:   sel = src.words[pend_offset[2]];
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            resp <= '0;
        end else begin
            resp.valid     <= pend_hit || miss_done;
            resp.load_data <= (pend_op == op_load) ? sel : 32'b0;   // stores answer zero
        end
    end

endmodule

`default_nettype wire

// File: dcache.sv
`timescale 1ns/1ps
`default_nettype none

module dcache (
    input  logic                                 clock,
    input  logic                                 reset,
    input  dcache_pkg::dcache_req_t              req,
    output logic                                 ready,
    output dcache_pkg::dcache_resp_t             resp,
    output dcache_pkg::mem_req_t                 mem_req,
    input  logic [dcache_pkg::mem_tag_bits-1:0]  mem_response,
    input  logic [dcache_pkg::mem_tag_bits-1:0]  mem_tag,
    input  dcache_pkg::line_t                    mem_data
);
    import dcache_pkg::*;

    decoded_req_t          dec;
    logic                  accept;
    logic                  main_hit;
    logic                  victim_hit;
    line_t                 hit_line;
    logic                  main_victim_valid;
    line_t                 lru_line;
    logic [addr_width-1:0] lru_addr;
    logic                  lru_valid;
    logic                  lru_dirty;
    logic                  fill_valid;
    line_t                 fill_line;
    logic                  miss_done;

    request_decode request_decode_inst (
        .req (req),
        .dec (dec)
    );

    line_store line_store_inst (
        .clock             (clock),
        .reset             (reset),
        .dec               (dec),
        .accept            (accept),
        .fill_valid        (fill_valid),
        .fill_line         (fill_line),
        .main_hit          (main_hit),
        .victim_hit        (victim_hit),
        .hit_line          (hit_line),
        .main_victim_valid (main_victim_valid),
        .lru_line          (lru_line),
        .lru_addr          (lru_addr),
        .lru_valid         (lru_valid),
        .lru_dirty         (lru_dirty)
    );

    miss_handler miss_handler_inst (
        .clock             (clock),
        .reset             (reset),
        .req_valid         (req.valid),
        .dec               (dec),
        .main_hit          (main_hit),
        .victim_hit        (victim_hit),
        .main_victim_valid (main_victim_valid),
        .lru_valid         (lru_valid),
        .lru_dirty         (lru_dirty),
        .lru_addr          (lru_addr),
        .lru_line          (lru_line),
        .mem_req           (mem_req),
        .mem_response      (mem_response),
        .mem_tag           (mem_tag),
        .mem_data          (mem_data),
        .ready             (ready),
        .accept            (accept),
        .fill_valid        (fill_valid),
        .fill_line         (fill_line),
        .miss_done         (miss_done)
    );

    load_align load_align_inst (
        .clock     (clock),
        .reset     (reset),
        .hit_line  (hit_line),
        .fill_line (fill_line),
        .accept    (accept),
        .hit       (main_hit | victim_hit),
        .miss_done (miss_done),
        .dec       (dec),
        .resp      (resp)
    );

endmodule

`default_nettype wire

// File: tb_dcache.sv
`timescale 1ns/1ps
`default_nettype none

module tb_dcache;
    import dcache_pkg::*;

    localparam int clock_period = 100;
    localparam int drive_delay  = 10;
    localparam int max_cycles   = 3000;     // roughly twice the slowest run of all tests
    localparam int n_random     = 40;

    logic                    clock;
    logic                    reset;
    dcache_req_t             req;
    logic                    ready;
    dcache_resp_t            resp;
    mem_req_t                mem_req;
    logic [mem_tag_bits-1:0] mem_response;
    logic [mem_tag_bits-1:0] mem_tag;
    line_t                   mem_data;

    int          seed = 32'h4969_9b35;
    int          cycle = 0;
    string       test_name;
    logic [7:0]  mem_bytes [logic [31:0]];  // memory model, only bytes written back
    logic [7:0]  shadow    [logic [31:0]];  // what the processor should see
    logic [31:0] exp_data_q [$];
    int          exp_cycle_q [$];           // -1 when the latency is free
    int          want_cycle;

    // memory model state
    int                      delay_left;
    int                      ret_wait;
    logic [mem_tag_bits-1:0] ret_tag;
    logic [mem_tag_bits-1:0] next_tag;
    line_t                   ret_data;

    // random requests, drawn before reset
    mem_op_e     rnd_op   [n_random];
    mem_size_e   rnd_size [n_random];
    logic [31:0] rnd_addr [n_random];
    logic [31:0] rnd_data [n_random];

    dcache dcache_inst (
        .clock        (clock),
        .reset        (reset),
        .req          (req),
        .ready        (ready),
        .resp         (resp),
        .mem_req      (mem_req),
        .mem_response (mem_response),
        .mem_tag      (mem_tag),
        .mem_data     (mem_data)
    );

    initial begin
        clock = 1'b0;
        forever #(clock_period/2) clock = ~clock;
    end

    always @(posedge clock) cycle <= cycle + 1;

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("*** FAILED ***");
        $fatal(1);
    endtask

    task automatic check_value(input string what, input logic [63:0] expected,
                               input logic [63:0] actual);
        assert (expected == actual)
        else abort_run($sformatf("Fail %s: expected %h, actual %h", what, expected, actual));
    endtask

    function automatic logic [7:0] pattern_byte(input logic [31:0] a);
        logic [31:0] p;
        p = a * 32'd7 + 32'd3;
        return p[7:0];
    endfunction

    function automatic logic [7:0] memory_byte(input logic [31:0] a);
        if (mem_bytes.exists(a))
            return mem_bytes[a];
        return pattern_byte(a);
    endfunction

    function automatic logic [7:0] shadow_byte(input logic [31:0] a);
        if (shadow.exists(a))
            return shadow[a];
        return pattern_byte(a);
    endfunction

    function automatic line_t shadow_line(input logic [31:0] base);
        line_t l;
        for (int b = 0; b < line_bytes; b++)
            l.bytes[b] = shadow_byte(base + 32'(b));
        return l;
    endfunction

    function automatic int size_bytes(input mem_size_e size);
        case (size)
            size_byte: return 1;
            size_half: return 2;
            default:   return 4;
        endcase
    endfunction

    // little endian, zero extended
    function automatic logic [31:0] expected_load(input logic [31:0] addr, input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++)
            v[8*i +: 8] = shadow_byte(addr + 32'(i));
        return v;
    endfunction

    // called at drive time, returns once the request has been taken
    task automatic issue(input mem_op_e op, input mem_size_e size, input logic [31:0] addr,
                         input logic [31:0] data, input logic must_hit);
        logic taken;
        int   n;
        n              = size_bytes(size);
        taken          = 1'b0;
        req.valid      = 1'b1;
        req.op         = op;
        req.size       = size;
        req.addr       = addr;
        req.store_data = data;
        if (must_hit)
            assert (ready)
            else abort_run($sformatf("%s: ready low for a hit to %h", test_name, addr));
        while (!taken) begin
            if (ready) begin                        // taken at the coming edge
                taken = 1'b1;
                if (op == op_store) begin
                    for (int i = 0; i < n; i++)
                        shadow[addr + 32'(i)] = data[8*i +: 8];
                    exp_data_q.push_back('0);
                end else begin
                    exp_data_q.push_back(expected_load(addr, n));
                end
                exp_cycle_q.push_back(must_hit ? cycle + 2 : -1);
            end
            @(posedge clock);
            #drive_delay;
        end
    endtask

    task automatic drain();
        req.valid = 1'b0;
        while (exp_data_q.size() != 0) begin
            @(posedge clock);
            #drive_delay;
        end
    endtask

    task automatic accept_command();
        logic [31:0] base;
        base = mem_req.addr;
        assert (base[offset_bits-1:0] == '0)
        else abort_run("memory command address is not line aligned");
        mem_response = next_tag;
        if (mem_req.command == bus_store) begin
            check_value({test_name, " write-back"}, shadow_line(base), mem_req.data);
            for (int b = 0; b < line_bytes; b++)
                mem_bytes[base + 32'(b)] = mem_req.data.bytes[b];
        end else begin
            for (int b = 0; b < line_bytes; b++)
                ret_data.bytes[b] = memory_byte(base + 32'(b));
            ret_tag  = next_tag;
            ret_wait = 2 + $unsigned($random(seed)) % 4;
        end
        next_tag = (next_tag == '1) ? 4'd1 : next_tag + 4'd1;   // never zero
    endtask

    // tagged memory, random accept delay of 0 to 3 cycles
    initial begin
        mem_response = '0;
        mem_tag      = '0;
        mem_data     = '0;
        delay_left   = -1;
        ret_wait     = 0;
        ret_tag      = '0;
        next_tag     = 4'd1;
        forever begin
            @(posedge clock);
            #drive_delay;
            mem_response = '0;
            mem_tag      = '0;
            if (ret_wait > 0) begin
                ret_wait = ret_wait - 1;
                if (ret_wait == 0) begin
                    mem_tag  = ret_tag;
                    mem_data = ret_data;
                end
            end
            if (!reset && mem_req.command != bus_none) begin
                if (delay_left < 0)
                    delay_left = $unsigned($random(seed)) % 4;
                if (delay_left == 0) begin
                    accept_command();
                    delay_left = -1;
                end else begin
                    delay_left = delay_left - 1;
                end
            end
        end
    end

    // response checker
    always begin
        @(posedge clock);
        #drive_delay;
        if (!reset && resp.valid) begin
            assert (exp_data_q.size() != 0)
            else abort_run("response valid with no accepted request outstanding");
            want_cycle = exp_cycle_q.pop_front();
            check_value(test_name, 64'(exp_data_q.pop_front()), 64'(resp.load_data));
            if (want_cycle >= 0)
                check_value({test_name, " latency"}, 64'(want_cycle), 64'(cycle));
        end
    end

    initial begin
        repeat (max_cycles) @(posedge clock);
        abort_run($sformatf("watchdog expired in %s with %0d responses missing",
                            test_name, exp_data_q.size()));
    end

    initial begin
        logic [31:0] r;
        logic [1:0]  sz;
        logic [31:0] base;
        reset     = 1'b1;
        req       = '0;
        test_name = "reset";
        for (int i = 0; i < n_random; i++) begin
            r = $random(seed);
            sz = r[9:8];
            if (sz == 2'd3)
                sz = 2'd2;
            rnd_op[i]   = r[0] ? op_store : op_load;
            rnd_size[i] = mem_size_e'(sz);
            rnd_addr[i] = (32'h3000 | {22'b0, r[19:10]})
                          & ~(32'(size_bytes(rnd_size[i])) - 32'd1);
            rnd_data[i] = $random(seed);
        end
        repeat (4) @(posedge clock);
        #drive_delay;
        reset = 1'b0;

        repeat (3) begin
            assert (ready && !resp.valid && mem_req.command == bus_none)
            else abort_run("DUT not idle after reset");
            @(posedge clock);
            #drive_delay;
        end

        test_name = "load_miss";
        issue(op_load, size_byte, 32'h0000_0101, '0, 1'b0);
        issue(op_load, size_half, 32'h0000_020a, '0, 1'b0);
        issue(op_load, size_word, 32'h0000_0314, '0, 1'b0);
        drain();

        test_name = "back_to_back";         // line 0x310 is resident now
        issue(op_load, size_word, 32'h0000_0310, '0, 1'b1);
        issue(op_load, size_byte, 32'h0000_0317, '0, 1'b1);
        issue(op_load, size_half, 32'h0000_0312, '0, 1'b1);
        issue(op_load, size_word, 32'h0000_0314, '0, 1'b1);
        drain();

        test_name = "store_load";
        issue(op_store, size_byte, 32'h0000_0101, 32'h0000_005a, 1'b0);
        issue(op_store, size_half, 32'h0000_0206, 32'h0000_c3d2, 1'b0);
        issue(op_store, size_word, 32'h0000_0400, 32'h1234_5678, 1'b0);
        issue(op_store, size_half, 32'h0000_0512, 32'h0000_beef, 1'b0);
        issue(op_load, size_word, 32'h0000_0100, '0, 1'b0);
        issue(op_load, size_half, 32'h0000_0100, '0, 1'b0);
        issue(op_load, size_word, 32'h0000_0204, '0, 1'b0);
        issue(op_load, size_byte, 32'h0000_0403, '0, 1'b0);
        issue(op_load, size_word, 32'h0000_0510, '0, 1'b0);
        issue(op_load, size_half, 32'h0000_0402, '0, 1'b0);
        drain();

        test_name = "victim_lru";           // six lines on index 5
        for (int k = 0; k < 6; k++) begin
            base = 32'h2028 + 32'(k) * 32'h80;
            issue(op_store, size_word, base + 32'd4, 32'ha5a5_0000 + 32'(k), 1'b0);
        end
        for (int k = 5; k >= 0; k--) begin
            base = 32'h2028 + 32'(k) * 32'h80;
            issue(op_load, size_word, base + 32'd4, '0, 1'b0);
            issue(op_load, size_byte, base + 32'd1, '0, 1'b0);
        end
        base = 32'h2028 + 32'd3 * 32'h80;
        issue(op_store, size_half, base + 32'd2, 32'h0000_7e7e, 1'b0);
        issue(op_load, size_word, base, '0, 1'b0);
        drain();

        test_name = "random";
        for (int i = 0; i < n_random; i++)
            issue(rnd_op[i], rnd_size[i], rnd_addr[i], rnd_data[i], 1'b0);
        drain();

        $display("*** PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

// File: flist.f
dcache_pkg.sv
request_decode.sv
line_store.sv
miss_handler.sv
load_align.sv
dcache.sv
tb_dcache.sv

// File: run.sh
#!/bin/sh
# build with Verilator, run, and look for the pass message in the output
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f flist.f --top-module tb_dcache -o sim_dcache &&
./obj_dir/sim_dcache | tee /dev/stderr | grep -F -e '*** PASSED ***' > /dev/null &&
echo "simulation passed" ||
{ echo "*** FAILED ***"; exit 1; }
